//--- Makefile
TOP = tb_cpuTop

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

//--- cpuTop.sv
`timescale 1ns/1ns
`default_nettype none

module cpuTop (
    input  logic                clk,
    input  logic                rst,
    input  logic                run,
    input  logic                imemWe,
    input  riscvPkg::imemAddr_t imemAddr,
    input  riscvPkg::word_t     imemData,
    output riscvPkg::retireT    retire
);

    // fetch/decode
    riscvPkg::word_t    instrD;
    riscvPkg::word_t    pcD;
    riscvPkg::word_t    rd1;
    riscvPkg::word_t    rd2;
    // execute
    riscvPkg::regAddr_t rs1E;
    riscvPkg::regAddr_t rs2E;
    riscvPkg::regAddr_t rdE;
    logic               takeBranch;
    riscvPkg::word_t    target;
    // memory
    riscvPkg::word_t    aluOutM;
    riscvPkg::word_t    storeDataM;
    riscvPkg::word_t    pcPlus4M;
    riscvPkg::regAddr_t rdM;
    // write-back
    riscvPkg::wbT       wb;
    // hazard controls
    riscvPkg::ctrlT     ctrlE;
    riscvPkg::ctrlT     ctrlM;
    riscvPkg::forward_e forwardA;
    riscvPkg::forward_e forwardB;
    logic               stall;
    logic               flush;

    fetchStage fetchStage_inst (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .stall      (stall),
        .flush      (flush),
        .takeBranch (takeBranch),
        .target     (target),
        .imemWe     (imemWe),
        .imemAddr   (imemAddr),
        .imemData   (imemData),
        .instrD     (instrD),
        .pcD        (pcD)
    );

    regFile regFile_inst (
        .clk (clk),
        .rs1 (instrD[19:15]),
        .rs2 (instrD[24:20]),
        .wb  (wb),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    pipelineControl pipelineControl_inst (
        .clk        (clk),
        .rst        (rst),
        .instrD     (instrD),
        .rs1E       (rs1E),
        .rs2E       (rs2E),
        .rdE        (rdE),
        .takeBranch (takeBranch),
        .wbM        (rdM),
        .wb         (wb),
        .ctrlE      (ctrlE),
        .ctrlM      (ctrlM),
        .forwardA   (forwardA),
        .forwardB   (forwardB),
        .stall      (stall),
        .flush      (flush)
    );

    // aluOutM doubles as the memory-stage forward value
    executeStage executeStage_inst (
        .clk        (clk),
        .rst        (rst),
        .instrD     (instrD),
        .pcD        (pcD),
        .rd1        (rd1),
        .rd2        (rd2),
        .ctrlE      (ctrlE),
        .stall      (stall),
        .flush      (flush),
        .forwardA   (forwardA),
        .forwardB   (forwardB),
        .aluResultM (aluOutM),
        .wb         (wb),
        .rs1E       (rs1E),
        .rs2E       (rs2E),
        .rdE        (rdE),
        .takeBranch (takeBranch),
        .target     (target),
        .aluOutM    (aluOutM),
        .storeDataM (storeDataM),
        .pcPlus4M   (pcPlus4M),
        .rdM        (rdM)
    );

    memoryStage memoryStage_inst (
        .clk        (clk),
        .rst        (rst),
        .ctrlM      (ctrlM),
        .aluOutM    (aluOutM),
        .storeDataM (storeDataM),
        .pcPlus4M   (pcPlus4M),
        .rdM        (rdM),
        .wb         (wb)
    );

    // one commit report per register write
    assign retire.valid = wb.regWrite && (wb.rd != '0);
    assign retire.rd    = wb.rd;
    assign retire.data  = wb.data;

endmodule

`default_nettype wire

//--- executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage (
    input  logic               clk,
    input  logic               rst,
    input  riscvPkg::word_t    instrD,
    input  riscvPkg::word_t    pcD,
    input  riscvPkg::word_t    rd1,
    input  riscvPkg::word_t    rd2,
    input  riscvPkg::ctrlT     ctrlE,
    input  logic               stall,
    input  logic               flush,
    input  riscvPkg::forward_e forwardA,
    input  riscvPkg::forward_e forwardB,
    input  riscvPkg::word_t    aluResultM,
    input  riscvPkg::wbT       wb,
    output riscvPkg::regAddr_t rs1E,
    output riscvPkg::regAddr_t rs2E,
    output riscvPkg::regAddr_t rdE,
    output logic               takeBranch,
    output riscvPkg::word_t    target,
    output riscvPkg::word_t    aluOutM,
    output riscvPkg::word_t    storeDataM,
    output riscvPkg::word_t    pcPlus4M,
    output riscvPkg::regAddr_t rdM
);

    riscvPkg::word_t immD;
    riscvPkg::word_t immE;
    riscvPkg::word_t rd1E;
    riscvPkg::word_t rd2E;
    riscvPkg::word_t pcE;
    riscvPkg::word_t srcA;
    riscvPkg::word_t writeDataE;
    riscvPkg::word_t srcB;
    riscvPkg::word_t aluResult;

    // immediate format picked by opcode, I by default
    always_comb begin
        case (instrD[6:0])
            riscvPkg::OP_STORE:  immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            riscvPkg::OP_BRANCH: immD = {{19{instrD[31]}}, instrD[31], instrD[7],
                                         instrD[30:25], instrD[11:8], 1'b0};
            riscvPkg::OP_JAL:    immD = {{11{instrD[31]}}, instrD[31], instrD[19:12],
                                         instrD[20], instrD[30:21], 1'b0};
            default:             immD = {{20{instrD[31]}}, instrD[31:20]};
        endcase
    end

    // decode/execute operands
    always_ff @(posedge clk) begin
        immE <= immD;
        rd1E <= rd1;
        rd2E <= rd2;
        pcE  <= pcD;
    end

    // register indices, x0 in a bubble
    always_ff @(posedge clk) begin
        if (rst || stall || flush) begin
            rs1E <= '0;
            rs2E <= '0;
            rdE  <= '0;
        end else begin
            rs1E <= instrD[19:15];
            rs2E <= instrD[24:20];
            rdE  <= instrD[11:7];
        end
    end

    function automatic riscvPkg::word_t fwdMux(input riscvPkg::forward_e sel,
                                               input riscvPkg::word_t regVal,
                                               input riscvPkg::word_t memVal,
                                               input riscvPkg::word_t wbVal);
        case (sel)
            riscvPkg::FROM_MEM: return memVal;
            riscvPkg::FROM_WB:  return wbVal;
            default:            return regVal;
        endcase
    endfunction

    assign srcA       = fwdMux(forwardA, rd1E, aluResultM, wb.data);
    assign writeDataE = fwdMux(forwardB, rd2E, aluResultM, wb.data);
    assign srcB       = ctrlE.aluSrcImm ? immE : writeDataE;

    always_comb begin
        case (ctrlE.aluOp)
            riscvPkg::SUB: aluResult = srcA - srcB;
            riscvPkg::AND: aluResult = srcA & srcB;
            riscvPkg::OR:  aluResult = srcA | srcB;
            riscvPkg::SLT: aluResult = ($signed(srcA) < $signed(srcB)) ? 32'd1 : 32'd0;
            default:       aluResult = srcA + srcB;
        endcase
    end

    // beq equal when the difference is zero
    assign takeBranch = ctrlE.jump || (ctrlE.branch && (aluResult == '0));
    assign target     = pcE + immE;

    // execute/memory register
    always_ff @(posedge clk) begin
        aluOutM    <= aluResult;
        storeDataM <= writeDataE;
        pcPlus4M   <= pcE + 32'd4;
        rdM        <= rdE;
    end

endmodule

`default_nettype wire

//--- fetchStage.sv
`timescale 1ns/1ns
`default_nettype none

module fetchStage (
    input  logic                clk,
    input  logic                rst,
    input  logic                run,
    input  logic                stall,
    input  logic                flush,
    input  logic                takeBranch,
    input  riscvPkg::word_t     target,
    input  logic                imemWe,
    input  riscvPkg::imemAddr_t imemAddr,
    input  riscvPkg::word_t     imemData,
    output riscvPkg::word_t     instrD,
    output riscvPkg::word_t     pcD
);

    riscvPkg::word_t     imem [riscvPkg::IMEM_DEPTH];
    riscvPkg::word_t     pc;
    riscvPkg::word_t     pcNext;
    riscvPkg::imemAddr_t fetchIdx;
    logic                pcAdvance;

    // byte pc to word index
    assign fetchIdx = pc[9:2];

    // program load port, used while run is low
    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr] <= imemData;
        end
    end

    // redirect beats stall
    assign pcNext    = takeBranch ? target : pc + 32'd4;
    assign pcAdvance = takeBranch || (run && !stall);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (pcAdvance) begin
            pc <= pcNext;
        end
    end

    // fetch/decode register
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            instrD <= riscvPkg::NOP_INSTR;
        end else if (!stall) begin
            if (run) begin
                instrD <= imem[fetchIdx];
                pcD    <= pc;
            end else begin
                // bubble while halted
                instrD <= riscvPkg::NOP_INSTR;
            end
        end
    end

endmodule

`default_nettype wire

//--- memoryStage.sv
`timescale 1ns/1ns
`default_nettype none

module memoryStage (
    input  logic               clk,
    input  logic               rst,
    input  riscvPkg::ctrlT     ctrlM,
    input  riscvPkg::word_t    aluOutM,
    input  riscvPkg::word_t    storeDataM,
    input  riscvPkg::word_t    pcPlus4M,
    input  riscvPkg::regAddr_t rdM,
    output riscvPkg::wbT       wb
);

    riscvPkg::word_t             dmem [riscvPkg::DMEM_DEPTH];
    logic [riscvPkg::DMEM_AW-1:0] dmemIdx;
    riscvPkg::word_t             aluOutW;
    riscvPkg::word_t             readDataW;
    riscvPkg::word_t             pcPlus4W;
    riscvPkg::regAddr_t          rdW;
    logic                        regWriteW;
    riscvPkg::resultSrc_e        resultSrcW;

    // word address, low two bits dropped
    assign dmemIdx = aluOutM[riscvPkg::DMEM_AW+1:2];

    // synchronous array, read lands in the write-back register
    always_ff @(posedge clk) begin
        if (ctrlM.memWrite) begin
            dmem[dmemIdx] <= storeDataM;
        end
        if (ctrlM.memRead) begin
            readDataW <= dmem[dmemIdx];
        end
    end

    always_ff @(posedge clk) begin
        aluOutW  <= aluOutM;
        pcPlus4W <= pcPlus4M;
        rdW      <= rdM;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            regWriteW  <= 1'b0;
            resultSrcW <= riscvPkg::ALU;
        end else begin
            regWriteW  <= ctrlM.regWrite;
            resultSrcW <= ctrlM.resultSrc;
        end
    end

    // write-back result select
    always_comb begin
        wb.regWrite = regWriteW;
        wb.rd       = rdW;
        case (resultSrcW)
            riscvPkg::MEM: wb.data = readDataW;
            riscvPkg::PC4: wb.data = pcPlus4W;
            default:       wb.data = aluOutW;
        endcase
    end

endmodule

`default_nettype wire

//--- pipelineControl.sv
`timescale 1ns/1ns
`default_nettype none

module pipelineControl (
    input  logic               clk,
    input  logic               rst,
    input  riscvPkg::word_t    instrD,
    input  riscvPkg::regAddr_t rs1E,
    input  riscvPkg::regAddr_t rs2E,
    input  riscvPkg::regAddr_t rdE,
    input  logic               takeBranch,
    input  riscvPkg::regAddr_t wbM,
    input  riscvPkg::wbT       wb,
    output riscvPkg::ctrlT     ctrlE,
    output riscvPkg::ctrlT     ctrlM,
    output riscvPkg::forward_e forwardA,
    output riscvPkg::forward_e forwardB,
    output logic               stall,
    output logic               flush
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic               funct7b5;
    riscvPkg::regAddr_t rs1D;
    riscvPkg::regAddr_t rs2D;
    riscvPkg::regAddr_t rdD;
    riscvPkg::ctrlT     ctrlD;
    logic               loadUse;

    // decode-stage fields
    assign opcode   = instrD[6:0];
    assign funct3   = instrD[14:12];
    assign funct7b5 = instrD[30];
    assign rs1D     = instrD[19:15];
    assign rs2D     = instrD[24:20];
    assign rdD      = instrD[11:7];

    always_comb begin
        ctrlD = '0;
        case (opcode)
            riscvPkg::OP_RTYPE: begin
                ctrlD.regWrite = 1'b1;
                case (funct3)
                    3'b000:  ctrlD.aluOp = funct7b5 ? riscvPkg::SUB : riscvPkg::ADD;
                    3'b010:  ctrlD.aluOp = riscvPkg::SLT;
                    3'b110:  ctrlD.aluOp = riscvPkg::OR;
                    3'b111:  ctrlD.aluOp = riscvPkg::AND;
                    // unsupported funct3 retires as a nop
                    default: ctrlD.regWrite = 1'b0;
                endcase
            end
            riscvPkg::OP_ITYPE: begin
                // addi only
                ctrlD.regWrite  = (funct3 == 3'b000);
                ctrlD.aluSrcImm = 1'b1;
            end
            riscvPkg::OP_LOAD: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.memRead   = 1'b1;
                ctrlD.aluSrcImm = 1'b1;
                ctrlD.resultSrc = riscvPkg::MEM;
            end
            riscvPkg::OP_STORE: begin
                ctrlD.memWrite  = 1'b1;
                ctrlD.aluSrcImm = 1'b1;
            end
            riscvPkg::OP_BRANCH: begin
                // beq compares via subtract
                ctrlD.branch = (funct3 == 3'b000);
                ctrlD.aluOp  = riscvPkg::SUB;
            end
            riscvPkg::OP_JAL: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.jump      = 1'b1;
                ctrlD.resultSrc = riscvPkg::PC4;
            end
            default: ctrlD = '0;
        endcase
        // x0 destination never writes back
        if (rdD == '0) begin
            ctrlD.regWrite = 1'b0;
        end
    end

    // load in execute feeding the decode instruction
    assign loadUse = ctrlE.memRead && (rdE != '0) && ((rdE == rs1D) || (rdE == rs2D));
    // taken branch or jal kills the two younger slots
    assign flush   = takeBranch;
    assign stall   = loadUse && !takeBranch;

    // control pipe D -> E -> M
    always_ff @(posedge clk) begin
        if (rst || flush || stall) begin
            ctrlE <= '0;
        end else begin
            ctrlE <= ctrlD;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrlM <= '0;
        end else begin
            ctrlM <= ctrlE;
        end
    end

    // memory stage is newer so it wins over write-back
    // x0 drops out here because its writes never carry regWrite
    function automatic riscvPkg::forward_e fwdSel(input riscvPkg::regAddr_t src);
        riscvPkg::forward_e sel;
        sel = riscvPkg::REG;
        if (ctrlM.regWrite && (wbM == src)) begin
            sel = riscvPkg::FROM_MEM;
        end else if (wb.regWrite && (wb.rd == src)) begin
            sel = riscvPkg::FROM_WB;
        end
        return sel;
    endfunction

    assign forwardA = fwdSel(rs1E);
    assign forwardB = fwdSel(rs2E);

    // forwarding must come from a real destination
    assert property (@(posedge clk) disable iff (rst)
        (forwardA == riscvPkg::FROM_MEM || forwardB == riscvPkg::FROM_MEM) |-> (wbM != '0))
        else $error("forward from memory stage with rd x0");

    assert property (@(posedge clk) disable iff (rst)
        (forwardA == riscvPkg::FROM_WB || forwardB == riscvPkg::FROM_WB) |-> (wb.rd != '0))
        else $error("forward from write-back with rd x0");

    // second slot behind a taken branch is the fetch bubble
    assert property (@(posedge clk) disable iff (rst)
        $past(flush, 2) |->
            !(ctrlE.regWrite || ctrlE.memWrite || ctrlE.branch || ctrlE.jump))
        else $error("ctrlE not a bubble two cycles after flush");

endmodule

`default_nettype wire

//--- regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  logic               clk,
    input  riscvPkg::regAddr_t rs1,
    input  riscvPkg::regAddr_t rs2,
    input  riscvPkg::wbT       wb,
    output riscvPkg::word_t    rd1,
    output riscvPkg::word_t    rd2
);

    riscvPkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (wb.regWrite && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // x0 is hardwired, same-cycle write passes through
    assign rd1 = (rs1 == '0) ? '0 :
                 (wb.regWrite && (wb.rd == rs1)) ? wb.data : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 :
                 (wb.regWrite && (wb.rd == rs2)) ? wb.data : regs[rs2];

    // decoder drops writes to x0 long before they get here
    assert property (@(posedge clk) wb.regWrite |-> (wb.rd != '0))
        else $error("write-back targets x0");

endmodule

`default_nettype wire

//--- riscvPkg.sv
`default_nettype none

package riscvPkg;

    // one data word or one instruction
    typedef logic [31:0] word_t;
    // architectural register index
    typedef logic [4:0]  regAddr_t;
    // word index into instruction memory
    typedef logic [7:0]  imemAddr_t;

    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 64;
    // data memory word index width
    localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

    // major opcodes of the supported subset
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        SLT = 3'd4
    } aluOp_e;

    typedef enum logic [1:0] {
        ALU = 2'd0,
        MEM = 2'd1,
        PC4 = 2'd2
    } resultSrc_e;

    // operand source for the execute stage
    typedef enum logic [1:0] {
        REG      = 2'b00,
        FROM_WB  = 2'b01,
        FROM_MEM = 2'b10
    } forward_e;

    // decoded controls of one instruction, all zero is a bubble
    typedef struct packed {
        logic       regWrite;
        logic       memWrite;
        logic       memRead;
        logic       branch;
        logic       jump;
        logic       aluSrcImm;
        aluOp_e     aluOp;
        resultSrc_e resultSrc;
    } ctrlT;

    typedef struct packed {
        logic     regWrite;
        regAddr_t rd;
        word_t    data;
    } wbT;

    typedef struct packed {
        logic     valid;
        regAddr_t rd;
        word_t    data;
    } retireT;

endpackage

`default_nettype wire

//--- sources.f
riscvPkg.sv
pipelineControl.sv
fetchStage.sv
regFile.sv
executeStage.sv
memoryStage.sv
cpuTop.sv
tb_cpuTop.sv

//--- tb_cpuTop.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpuTop;

    localparam int NUM_PROGS    = 6;
    localparam int MAX_INSTR    = 200;
    localparam int PREAMBLE     = 7;
    localparam int ABORT_PROG   = 3;
    localparam int DRAIN_CYCLES = 10;
    // longest stretch without a write before the core counts as parked
    localparam int QUIET_CYCLES = 50;
    // 20 cycles for every instruction slot of every program
    localparam int WATCHDOG_CYCLES = NUM_PROGS * MAX_INSTR * 20;

    typedef logic [riscvPkg::DMEM_AW-1:0] dmemIdx_t;

    logic                clk;
    logic                rst;
    logic                run;
    logic                imemWe;
    riscvPkg::imemAddr_t imemAddr;
    riscvPkg::word_t     imemData;
    riscvPkg::retireT    retire;

    // program image and reference state
    riscvPkg::word_t     progMem [riscvPkg::IMEM_DEPTH];
    riscvPkg::word_t     mregs [32];
    riscvPkg::word_t     mdmem [riscvPkg::DMEM_DEPTH];
    logic [riscvPkg::DMEM_DEPTH-1:0] dmemValid;
    dmemIdx_t            writtenIdx [$];
    riscvPkg::retireT    modelQ [$];
    riscvPkg::retireT    expQ [$];
    int                  expCount;
    int                  retiredCount;
    int                  quietCycles;

    cpuTop cpuTop_inst (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .imemWe   (imemWe),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .retire   (retire)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stopWithFailure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compareRetire(input riscvPkg::retireT got, input riscvPkg::retireT exp);
        if (got !== exp) begin
            stopWithFailure($sformatf("error at %0t ns: retire x%0d=%h, expected x%0d=%h",
                                      $time, got.rd, got.data, exp.rd, exp.data));
        end
    endtask

    task automatic matchCount(input riscvPkg::word_t got, input riscvPkg::word_t exp);
        if (got !== exp) begin
            stopWithFailure($sformatf("error at %0t ns: %0d writes retired, expected %0d",
                                      $time, got, exp));
        end
    endtask

    // instruction encoders, straight from the RV32I formats
    function automatic riscvPkg::word_t rType(input logic f7b5, input riscvPkg::regAddr_t rs2,
                                              input riscvPkg::regAddr_t rs1,
                                              input logic [2:0] f3,
                                              input riscvPkg::regAddr_t rd);
        return {1'b0, f7b5, 5'b0, rs2, rs1, f3, rd, riscvPkg::OP_RTYPE};
    endfunction

    function automatic riscvPkg::word_t iType(input riscvPkg::word_t imm,
                                              input riscvPkg::regAddr_t rs1,
                                              input logic [2:0] f3,
                                              input riscvPkg::regAddr_t rd,
                                              input logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic riscvPkg::word_t sType(input riscvPkg::word_t imm,
                                              input riscvPkg::regAddr_t rs2,
                                              input riscvPkg::regAddr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], riscvPkg::OP_STORE};
    endfunction

    function automatic riscvPkg::word_t bType(input riscvPkg::word_t off,
                                              input riscvPkg::regAddr_t rs2,
                                              input riscvPkg::regAddr_t rs1);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], riscvPkg::OP_BRANCH};
    endfunction

    function automatic riscvPkg::word_t jType(input riscvPkg::word_t off,
                                              input riscvPkg::regAddr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, riscvPkg::OP_JAL};
    endfunction

    // sign-extended 12-bit immediate
    function automatic riscvPkg::word_t randImm();
        riscvPkg::word_t v;
        v = $urandom;
        return {{20{v[11]}}, v[11:0]};
    endfunction

    // x0 stays zero and never reports
    task automatic modelWrite(input riscvPkg::regAddr_t rd, input riscvPkg::word_t value);
        if (rd != '0) begin
            mregs[rd] = value;
            modelQ.push_back(riscvPkg::retireT'{1'b1, rd, value});
            expCount++;
        end
    endtask

    // generate one program and run it on the model in the same pass
    task automatic buildProgram();
        int                 progLen;
        int                 idx;
        int                 execIdx;
        int                 kind;
        int                 off;
        riscvPkg::regAddr_t rd;
        riscvPkg::regAddr_t rs1;
        riscvPkg::regAddr_t rs2;
        riscvPkg::regAddr_t lastRd;
        riscvPkg::word_t    imm;
        riscvPkg::word_t    instr;
        dmemIdx_t           slot;
        logic [2:0]         f3;
        logic               f7b5;
        logic               doExec;
        modelQ.delete();
        writtenIdx.delete();
        expCount  = 0;
        dmemValid = '0;
        mregs[0]  = '0;
        for (int i = 0; i < riscvPkg::IMEM_DEPTH; i++) begin
            progMem[riscvPkg::imemAddr_t'(i)] = iType('0, '0, 3'b000, '0, riscvPkg::OP_ITYPE);
        end
        // last index holds the jal-to-self
        progLen = $urandom_range(MAX_INSTR - 1, 40);
        // x1..x7 get defined values before any read
        for (idx = 1; idx <= PREAMBLE; idx++) begin
            rd  = riscvPkg::regAddr_t'(idx);
            imm = randImm();
            progMem[riscvPkg::imemAddr_t'(idx - 1)] =
                iType(imm, '0, 3'b000, rd, riscvPkg::OP_ITYPE);
            modelWrite(rd, imm);
        end
        execIdx = PREAMBLE;
        lastRd  = riscvPkg::regAddr_t'(PREAMBLE);
        for (idx = PREAMBLE; idx < progLen; idx++) begin
            kind = $urandom_range(9, 0);
            rd   = riscvPkg::regAddr_t'($urandom_range(7, 0));
            // lean on the previous destination to build hazards
            rs1  = ($urandom_range(1, 0) == 1) ? lastRd : riscvPkg::regAddr_t'($urandom_range(7, 0));
            rs2  = ($urandom_range(3, 0) == 0) ? lastRd : riscvPkg::regAddr_t'($urandom_range(7, 0));
            imm  = randImm();
            slot = dmemIdx_t'($urandom_range(riscvPkg::DMEM_DEPTH - 1, 0));
            // forward targets, never past the final jal
            off  = $urandom_range(4, 1);
            if (off > progLen - idx) begin
                off = progLen - idx;
            end
            if (kind == 6 && writtenIdx.size() == 0) begin
                kind = 7;
            end
            if (kind == 6) begin
                slot = writtenIdx[$urandom_range(writtenIdx.size() - 1, 0)];
            end
            if (kind == 8 && $urandom_range(1, 0) == 1) begin
                rs2 = rs1;
            end
            doExec = (idx == execIdx);
            case (kind)
                0, 1, 2, 3, 4: begin
                    f7b5 = (kind == 1);
                    f3   = (kind == 2) ? 3'b111 : (kind == 3) ? 3'b110 :
                           (kind == 4) ? 3'b010 : 3'b000;
                    instr = rType(f7b5, rs2, rs1, f3, rd);
                end
                5: instr = iType(imm, rs1, 3'b000, rd, riscvPkg::OP_ITYPE);
                6: instr = iType({24'b0, slot, 2'b00}, '0, 3'b010, rd, riscvPkg::OP_LOAD);
                7: instr = sType({24'b0, slot, 2'b00}, rs2, '0);
                8: instr = bType(riscvPkg::word_t'(off * 4), rs2, rs1);
                default: instr = jType(riscvPkg::word_t'(off * 4), rd);
            endcase
            progMem[riscvPkg::imemAddr_t'(idx)] = instr;
            if (doExec) begin
                execIdx = idx + 1;
                case (kind)
                    0: modelWrite(rd, mregs[rs1] + mregs[rs2]);
                    1: modelWrite(rd, mregs[rs1] - mregs[rs2]);
                    2: modelWrite(rd, mregs[rs1] & mregs[rs2]);
                    3: modelWrite(rd, mregs[rs1] | mregs[rs2]);
                    4: modelWrite(rd, ($signed(mregs[rs1]) < $signed(mregs[rs2])) ? 32'd1 : 32'd0);
                    5: modelWrite(rd, mregs[rs1] + imm);
                    6: modelWrite(rd, mdmem[slot]);
                    7: begin
                        mdmem[slot] = mregs[rs2];
                        if (!dmemValid[slot]) begin
                            dmemValid[slot] = 1'b1;
                            writtenIdx.push_back(slot);
                        end
                    end
                    8: begin
                        if (mregs[rs1] == mregs[rs2]) begin
                            execIdx = idx + off;
                        end
                    end
                    default: begin
                        modelWrite(rd, riscvPkg::word_t'(idx * 4 + 4));
                        execIdx = idx + off;
                    end
                endcase
            end
            if (kind != 7 && kind != 8) begin
                lastRd = rd;
            end
        end
        // park the core on jal x0, 0
        progMem[riscvPkg::imemAddr_t'(progLen)] = jType('0, '0);
    endtask

    task automatic loadProgram();
        for (int i = 0; i < riscvPkg::IMEM_DEPTH; i++) begin
            @(negedge clk);
            imemWe   = 1'b1;
            imemAddr = riscvPkg::imemAddr_t'(i);
            imemData = progMem[riscvPkg::imemAddr_t'(i)];
        end
        @(negedge clk);
        imemWe = 1'b0;
    endtask

    task automatic resetCore();
        @(negedge clk);
        rst = 1'b1;
        run = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
    endtask

    // retire is registered, so mid-cycle sampling is stable
    initial begin
        forever begin
            @(negedge clk);
            if (retire.valid === 1'b1) begin
                if (expQ.size() == 0) begin
                    stopWithFailure($sformatf("error at %0t ns: retire of x%0d with no write pending",
                                              $time, retire.rd));
                end else begin
                    compareRetire(retire, expQ.pop_front());
                    retiredCount++;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stopWithFailure("watchdog timeout: the core stopped retiring the expected writes");
    end

    initial begin
        void'($urandom(52521));
        rst          = 1'b1;
        run          = 1'b0;
        imemWe       = 1'b0;
        imemAddr     = '0;
        imemData     = '0;
        retiredCount = 0;
        expCount     = 0;
        quietCycles  = 0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            resetCore();
            buildProgram();
            // queue stays empty during the load, any retire there is an error
            loadProgram();
            retiredCount = 0;
            @(negedge clk);
            expQ = modelQ;
            run  = 1'b1;
            if (p == ABORT_PROG) begin
                // pull reset with writes still in flight
                while (retiredCount < 4) begin
                    @(negedge clk);
                end
                rst = 1'b1;
                run = 1'b0;
                @(posedge clk);
                expQ.delete();
            end else begin
                // a core parked with writes missing also ends the wait
                quietCycles = 0;
                while (expQ.size() != 0 && quietCycles < QUIET_CYCLES) begin
                    @(negedge clk);
                    quietCycles = (retire.valid === 1'b1) ? 0 : quietCycles + 1;
                end
                repeat (DRAIN_CYCLES) @(negedge clk);
                run = 1'b0;
                matchCount(riscvPkg::word_t'(retiredCount), riscvPkg::word_t'(expCount));
            end
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
